// ==== design/mem_settings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Line geometry shared by both caches and the memory port
`define MEM_LINE_BITS 256

// One memory beat moves a quarter of a line
`define MEM_BEAT_BITS 64

`define MEM_BEATS 4

// Sets per direct-mapped cache, any power of two
`define MEM_SETS 16

// Instructions returned per fetch (1 or 2)
`define MEM_FETCH_WORDS 2

`endif

// ==== design/mem_pkg.sv ====
package mem_pkg;

`include "mem_settings.svh"

    // Core-side request held until resp pulses
    typedef struct packed {
        logic [31:0] addr;
        logic        rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
    } core_req_t;

    // Cache to arbiter, one whole line per transfer
    typedef struct packed {
        logic [31:0]               addr;
        logic                      read;
        logic                      write;
        logic [`MEM_LINE_BITS-1:0] wdata;
    } line_req_t;

    typedef struct packed {
        logic [`MEM_LINE_BITS-1:0] rdata;
        logic                      done;
    } line_rsp_t;

    // Banked memory port, one beat per transfer
    typedef struct packed {
        logic [31:0]               addr;
        logic                      read;
        logic                      write;
        logic [`MEM_BEAT_BITS-1:0] wdata;
    } bmem_req_t;

    typedef struct packed {
        logic [`MEM_BEAT_BITS-1:0] rdata;
        logic [31:0]               raddr;
        logic                      rvalid;
    } bmem_rsp_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_WRITEBACK,
        ST_ALLOCATE
    } cache_state_e;

    typedef enum logic {
        SRC_INST,
        SRC_DATA
    } bmem_src_e;

endpackage

// ==== design/line_cache.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module line_cache #(
    parameter bit WRITABLE  = 1'b1,
    parameter int READ_BITS = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_pkg::core_req_t    req,
    output logic [READ_BITS-1:0]  rdata,
    output logic                  resp,
    output mem_pkg::line_req_t    dfp_req,
    input  mem_pkg::line_rsp_t    dfp_rsp
);

    import mem_pkg::*;

    localparam int OFF_BITS = $clog2(`MEM_LINE_BITS / 8);
    localparam int IDX_BITS = $clog2(`MEM_SETS);
    localparam int TAG_BITS = 32 - OFF_BITS - IDX_BITS;
    localparam int RD_LSB   = $clog2(READ_BITS / 8);
    localparam int WORDS    = `MEM_LINE_BITS / 32;

    cache_state_e state;

    // Line storage and tags per set
    logic [`MEM_LINE_BITS-1:0] data_q [`MEM_SETS];
    logic [TAG_BITS-1:0]       tag_q [`MEM_SETS];
    logic [`MEM_SETS-1:0]      valid_q;
    logic [`MEM_SETS-1:0]      dirty_q;

    logic [IDX_BITS-1:0]        idx;
    logic [TAG_BITS-1:0]        tag;
    logic [OFF_BITS-RD_LSB-1:0] rd_sel;
    logic [$clog2(WORDS)-1:0]   wr_sel;
    logic [`MEM_LINE_BITS-1:0]  line_rd;
    logic [`MEM_LINE_BITS-1:0]  line_wr;
    logic                       req_present;
    logic                       wr_en;
    logic                       hit;

    assign tag    = req.addr[31 -: TAG_BITS];
    assign idx    = req.addr[OFF_BITS +: IDX_BITS];
    assign rd_sel = req.addr[OFF_BITS-1:RD_LSB];
    assign wr_sel = req.addr[OFF_BITS-1:2];

    assign req_present = req.rmask || (|req.wmask);
    assign wr_en       = WRITABLE && (|req.wmask);

    assign line_rd = data_q[idx];
    assign hit     = valid_q[idx] && (tag_q[idx] == tag);

    // Hits answer in the compare cycle, one cycle after idle saw the request
    assign resp  = (state == ST_COMPARE) && hit;
    assign rdata = line_rd[rd_sel*READ_BITS +: READ_BITS];

    // Byte merge of the store into the resident line
    always_comb begin
        line_wr = line_rd;
        for (int b = 0; b < 4; b++) begin
            if (req.wmask[b]) begin
                line_wr[wr_sel*32 + b*8 +: 8] = req.wdata[b*8 +: 8];
            end
        end
    end

    always_comb begin
        dfp_req.addr  = {tag, idx, {OFF_BITS{1'b0}}};
        dfp_req.read  = (state == ST_ALLOCATE);
        dfp_req.write = (state == ST_WRITEBACK);
        dfp_req.wdata = line_rd;
        // Victim goes back to the address it was filled from
        if (state == ST_WRITEBACK) begin
            dfp_req.addr = {tag_q[idx], idx, {OFF_BITS{1'b0}}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_present) begin
                        state <= ST_COMPARE;
                    end
                end
                ST_COMPARE: begin
                    if (hit) begin
                        state <= ST_IDLE;
                        if (wr_en) begin
                            dirty_q[idx] <= 1'b1;
                        end
                    end else if (valid_q[idx] && dirty_q[idx]) begin
                        state <= ST_WRITEBACK;
                    end else begin
                        state <= ST_ALLOCATE;
                    end
                end
                ST_WRITEBACK: begin
                    if (dfp_rsp.done) begin
                        state <= ST_ALLOCATE;
                    end
                end
                ST_ALLOCATE: begin
                    // Refilled line is clean and compare answers next
                    if (dfp_rsp.done) begin
                        valid_q[idx] <= 1'b1;
                        dirty_q[idx] <= 1'b0;
                        state        <= ST_COMPARE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_ALLOCATE && dfp_rsp.done) begin
            data_q[idx] <= dfp_rsp.rdata;
            tag_q[idx]  <= tag;
        end else if (state == ST_COMPARE && hit && wr_en) begin
            data_q[idx] <= line_wr;
        end
    end

    // Core must not store through a read-only port
    a_no_store_ro: assert property (@(posedge clk) disable iff (rst)
        (req.wmask != '0) |-> WRITABLE);

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(dfp_req.read && dfp_req.write));

endmodule

// ==== design/burst_arbiter.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module burst_arbiter (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::line_req_t  i_req,
    output mem_pkg::line_rsp_t  i_rsp,
    input  mem_pkg::line_req_t  d_req,
    output mem_pkg::line_rsp_t  d_rsp,
    output mem_pkg::bmem_req_t  bmem_req,
    input  logic                ready,
    input  mem_pkg::bmem_rsp_t  bmem_rsp
);

    import mem_pkg::*;

    localparam int CNT_BITS = $clog2(`MEM_BEATS);
    localparam int BEAT     = `MEM_BEAT_BITS;
    localparam logic [CNT_BITS-1:0] LAST = CNT_BITS'(`MEM_BEATS - 1);

    // Shared by write-back and read assembly since they never overlap
    logic [BEAT-1:0]           beat_buf [`MEM_BEATS-1];
    logic [CNT_BITS-1:0]       cnt;
    logic                      wb_active;
    logic                      d_held;
    logic                      lock_valid;
    bmem_src_e                 lock_src;
    logic [1:0]                pend_valid;
    logic [31:0]               pend_addr [2];
    bmem_src_e                 sel;
    logic                      i_want;
    logic                      d_rd_want;
    logic                      d_wr_want;
    logic                      d_want;
    logic                      accept;
    logic                      last_beat;
    logic                      route_i;
    logic                      route_d;
    logic [`MEM_LINE_BITS-1:0] line;

    assign i_want    = i_req.read && !pend_valid[SRC_INST];
    assign d_rd_want = d_req.read && !pend_valid[SRC_DATA];
    // Write-back waits until no read can return into the shared buffer
    assign d_wr_want = d_req.write && !wb_active && (pend_valid == '0);
    assign d_want    = d_rd_want || d_wr_want;

    // A stalled request keeps its source; a held data request beats new fetches
    always_comb begin
        if (lock_valid) begin
            sel = lock_src;
        end else if (d_held) begin
            sel = SRC_DATA;
        end else if (i_want) begin
            sel = SRC_INST;
        end else begin
            sel = SRC_DATA;
        end
    end

    always_comb begin
        bmem_req.addr  = i_req.addr;
        bmem_req.read  = 1'b0;
        bmem_req.write = 1'b0;
        bmem_req.wdata = d_req.wdata[BEAT-1:0];
        if (wb_active) begin
            bmem_req.addr  = d_req.addr;
            bmem_req.write = 1'b1;
            bmem_req.wdata = beat_buf[cnt - 1'b1];
        end else if (sel == SRC_DATA) begin
            bmem_req.addr  = d_req.addr;
            bmem_req.read  = d_rd_want;
            bmem_req.write = d_wr_want;
        end else begin
            bmem_req.read = i_want;
        end
    end

    assign accept    = (bmem_req.read || bmem_req.write) && ready && !wb_active;
    assign last_beat = bmem_rsp.rvalid && (cnt == LAST) && !wb_active;

    always_comb begin
        for (int k = 0; k < `MEM_BEATS - 1; k++) begin
            line[k*BEAT +: BEAT] = beat_buf[k];
        end
        line[`MEM_LINE_BITS-BEAT +: BEAT] = bmem_rsp.rdata;
    end

    // Instructions take the first copy of a line both sides wait for
    assign route_i = last_beat && pend_valid[SRC_INST]
                     && (pend_addr[SRC_INST] == bmem_rsp.raddr);
    assign route_d = last_beat && !route_i && pend_valid[SRC_DATA]
                     && (pend_addr[SRC_DATA] == bmem_rsp.raddr);

    assign i_rsp.rdata = line;
    assign i_rsp.done  = route_i;
    assign d_rsp.rdata = line;
    assign d_rsp.done  = route_d || (wb_active && ready && cnt == LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt        <= '0;
            wb_active  <= 1'b0;
            d_held     <= 1'b0;
            lock_valid <= 1'b0;
            pend_valid <= '0;
        end else begin
            lock_valid <= (bmem_req.read || bmem_req.write) && !ready && !wb_active;
            if (wb_active) begin
                if (ready) begin
                    cnt <= (cnt == LAST) ? '0 : cnt + 1'b1;
                    if (cnt == LAST) begin
                        wb_active <= 1'b0;
                    end
                end
            end else if (accept && bmem_req.write) begin
                cnt       <= CNT_BITS'(1);
                wb_active <= 1'b1;
            end else if (bmem_rsp.rvalid) begin
                cnt <= (cnt == LAST) ? '0 : cnt + 1'b1;
            end
            if (accept) begin
                if (sel == SRC_DATA) begin
                    d_held <= 1'b0;
                end else if (d_want) begin
                    d_held <= 1'b1;
                end
            end
            if (route_i) begin
                pend_valid[SRC_INST] <= 1'b0;
            end
            if (route_d) begin
                pend_valid[SRC_DATA] <= 1'b0;
            end
            if (accept && bmem_req.read) begin
                pend_valid[sel] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        lock_src <= sel;
        if (accept && bmem_req.read) begin
            pend_addr[sel] <= bmem_req.addr;
        end
        // Upper beats wait in the buffer while beat 0 leaves directly
        if (accept && bmem_req.write) begin
            for (int k = 0; k < `MEM_BEATS - 1; k++) begin
                beat_buf[k] <= d_req.wdata[(k+1)*BEAT +: BEAT];
            end
        end else if (bmem_rsp.rvalid && cnt != LAST) begin
            beat_buf[cnt] <= bmem_rsp.rdata;
        end
    end

    a_no_wr_pend_d: assert property (@(posedge clk) disable iff (rst)
        bmem_req.write |-> !pend_valid[SRC_DATA]);

    a_rvalid_owned: assert property (@(posedge clk) disable iff (rst)
        bmem_rsp.rvalid |->
            (pend_valid[SRC_INST] && pend_addr[SRC_INST] == bmem_rsp.raddr)
            || (pend_valid[SRC_DATA] && pend_addr[SRC_DATA] == bmem_rsp.raddr));

    a_inst_no_write: assert property (@(posedge clk) disable iff (rst)
        !i_req.write);

endmodule

// ==== design/mem_subsystem.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module mem_subsystem (
    input  logic                              clk,
    input  logic                              rst,
    input  mem_pkg::core_req_t                imem_req,
    output logic [32*`MEM_FETCH_WORDS-1:0]    imem_rdata,
    output logic                              imem_resp,
    input  mem_pkg::core_req_t                dmem_req,
    output logic [31:0]                       dmem_rdata,
    output logic                              dmem_resp,
    output mem_pkg::bmem_req_t                bmem_req,
    input  logic                              bmem_ready,
    input  mem_pkg::bmem_rsp_t                bmem_rsp
);

    import mem_pkg::*;

    line_req_t i_line_req;
    line_rsp_t i_line_rsp;
    line_req_t d_line_req;
    line_rsp_t d_line_rsp;

    // Read-only fetch side
    line_cache #(
        .WRITABLE  (1'b0),
        .READ_BITS (32*`MEM_FETCH_WORDS)
    ) inst_cache (
        .clk     (clk),
        .rst     (rst),
        .req     (imem_req),
        .rdata   (imem_rdata),
        .resp    (imem_resp),
        .dfp_req (i_line_req),
        .dfp_rsp (i_line_rsp)
    );

    line_cache #(
        .WRITABLE  (1'b1),
        .READ_BITS (32)
    ) data_cache (
        .clk     (clk),
        .rst     (rst),
        .req     (dmem_req),
        .rdata   (dmem_rdata),
        .resp    (dmem_resp),
        .dfp_req (d_line_req),
        .dfp_rsp (d_line_rsp)
    );

    burst_arbiter arbiter (
        .clk      (clk),
        .rst      (rst),
        .i_req    (i_line_req),
        .i_rsp    (i_line_rsp),
        .d_req    (d_line_req),
        .d_rsp    (d_line_rsp),
        .bmem_req (bmem_req),
        .ready    (bmem_ready),
        .bmem_rsp (bmem_rsp)
    );

endmodule

// ==== tb/bmem_model.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module bmem_model #(
    parameter int READ_DELAY = 6,
    parameter int STALL_PCT  = 25
) (
    input  logic               clk,
    input  logic               rst,
    input  mem_pkg::bmem_req_t req,
    output logic               ready,
    output mem_pkg::bmem_rsp_t rsp
);

    import mem_pkg::*;

    localparam int BEAT_BYTES = `MEM_BEAT_BITS / 8;
    localparam int BEAT_WORDS = `MEM_BEAT_BITS / 32;

    // Sparse backing store with the fill rule for unwritten words
    logic [31:0] mem [logic [31:0]];
    logic [31:0] rd_addr_q [$];
    int          rd_due_q [$];
    logic [31:0] burst_addr;
    int          burst_beat;
    logic        burst_busy;
    int          wr_beat;
    int          cycle;

    function automatic logic [31:0] word_at(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    initial begin
        ready      = 1'b0;
        rsp        = '0;
        burst_addr = '0;
        burst_beat = 0;
        burst_busy = 1'b0;
        wr_beat    = 0;
        cycle      = 0;
        forever begin
            // Requests have settled by mid-cycle
            @(negedge clk);
            if (rst) begin
                wr_beat = 0;
                rd_addr_q.delete();
                rd_due_q.delete();
            end else if (ready && req.write) begin
                for (int w = 0; w < BEAT_WORDS; w++) begin
                    mem[req.addr + 32'(wr_beat*BEAT_BYTES + 4*w)] = req.wdata[w*32 +: 32];
                end
                wr_beat = (wr_beat + 1) % `MEM_BEATS;
            end else if (ready && req.read) begin
                rd_addr_q.push_back(req.addr);
                rd_due_q.push_back(cycle + READ_DELAY);
            end

            @(posedge clk);
            #1;
            cycle++;
            rsp = '0;
            if (rst) begin
                ready      = 1'b0;
                burst_busy = 1'b0;
            end else begin
                ready = ($urandom_range(99) >= STALL_PCT);
                // Bursts go out whole and in request order
                if (!burst_busy && rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
                    burst_addr = rd_addr_q.pop_front();
                    void'(rd_due_q.pop_front());
                    burst_beat = 0;
                    burst_busy = 1'b1;
                end
                if (burst_busy) begin
                    rsp.rvalid = 1'b1;
                    rsp.raddr  = burst_addr;
                    for (int w = 0; w < BEAT_WORDS; w++) begin
                        rsp.rdata[w*32 +: 32] =
                            word_at(burst_addr + 32'(burst_beat*BEAT_BYTES + 4*w));
                    end
                    burst_beat++;
                    if (burst_beat == `MEM_BEATS) begin
                        burst_busy = 1'b0;
                    end
                end
            end
        end
    end

endmodule

// ==== tb/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`include "mem_settings.svh"

module tb_mem_subsystem;

    import mem_pkg::*;

    localparam int CLK_HALF    = 2;
    localparam int CYCLES_STEP = 200;
    localparam int FETCH_BITS  = 32 * `MEM_FETCH_WORDS;
    localparam int FETCH_BYTES = 4 * `MEM_FETCH_WORDS;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } op_e;

    typedef enum logic {
        PORT_INST,
        PORT_DATA
    } port_e;

    // A paired row starts in the same cycle as the row after it
    typedef struct packed {
        op_e         op;
        port_e       port;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  mask;
        logic [63:0] expected;
        logic        check_lat;
        logic        paired;
    } step_t;

    logic                  clk;
    logic                  rst;
    core_req_t             imem_req;
    logic [FETCH_BITS-1:0] imem_rdata;
    logic                  imem_resp;
    core_req_t             dmem_req;
    logic [31:0]           dmem_rdata;
    logic                  dmem_resp;
    bmem_req_t             bmem_req;
    logic                  bmem_ready;
    bmem_rsp_t             bmem_rsp;

    step_t       steps [$];
    logic [31:0] shadow [logic [31:0]];
    int          errors;
    int          cur_step;
    logic        table_ready;

    mem_subsystem UUT (
        .clk        (clk),
        .rst        (rst),
        .imem_req   (imem_req),
        .imem_rdata (imem_rdata),
        .imem_resp  (imem_resp),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .dmem_resp  (dmem_resp),
        .bmem_req   (bmem_req),
        .bmem_ready (bmem_ready),
        .bmem_rsp   (bmem_rsp)
    );

    bmem_model memory (
        .clk   (clk),
        .rst   (rst),
        .req   (bmem_req),
        .ready (bmem_ready),
        .rsp   (bmem_rsp)
    );

    initial begin
        clk = 1'b0;
    end

    always #CLK_HALF clk = ~clk;

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    // Expected values come from the shadow as it stands when the row is added
    function automatic void add_step(input op_e op, input port_e port,
                                     input logic [31:0] addr, input logic [31:0] wdata,
                                     input logic [3:0] mask, input logic check_lat,
                                     input logic paired);
        step_t       s;
        logic [31:0] base;
        logic [31:0] word;
        s.op        = op;
        s.port      = port;
        s.addr      = addr;
        s.wdata     = wdata;
        s.mask      = mask;
        s.check_lat = check_lat;
        s.paired    = paired;
        s.expected  = '0;
        if (port == PORT_INST) begin
            base = addr & ~(32'(FETCH_BYTES) - 32'd1);
            for (int w = 0; w < `MEM_FETCH_WORDS; w++) begin
                s.expected[w*32 +: 32] = shadow_word(base + 32'(4*w));
            end
        end else if (op == OP_READ) begin
            s.expected[31:0] = shadow_word(addr & ~32'h3);
        end else begin
            word = shadow_word(addr & ~32'h3);
            for (int b = 0; b < 4; b++) begin
                if (mask[b]) begin
                    word[b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            shadow[addr & ~32'h3] = word;
        end
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        // Fetch miss, then hits in the same line
        add_step(OP_READ,  PORT_INST, 32'h0000_1008, 32'h0, 4'h0, 1'b0, 1'b0);
        add_step(OP_READ,  PORT_INST, 32'h0000_1008, 32'h0, 4'h0, 1'b1, 1'b0);
        add_step(OP_READ,  PORT_INST, 32'h0000_1010, 32'h0, 4'h0, 1'b1, 1'b0);
        // Several words of one data line
        add_step(OP_READ,  PORT_DATA, 32'h0000_8000, 32'h0, 4'h0, 1'b0, 1'b0);
        add_step(OP_READ,  PORT_DATA, 32'h0000_8004, 32'h0, 4'h0, 1'b1, 1'b0);
        add_step(OP_READ,  PORT_DATA, 32'h0000_801c, 32'h0, 4'h0, 1'b1, 1'b0);
        // Byte merge on a hit
        add_step(OP_WRITE, PORT_DATA, 32'h0000_8008, 32'hdeadbeef, 4'h5, 1'b0, 1'b0);
        add_step(OP_READ,  PORT_DATA, 32'h0000_8008, 32'h0, 4'h0, 1'b0, 1'b0);
        // Write-allocate into set 2, evict it dirty, then read it back
        add_step(OP_WRITE, PORT_DATA, 32'h0000_8044, 32'h12345678, 4'hf, 1'b0, 1'b0);
        add_step(OP_READ,  PORT_DATA, 32'h0000_8244, 32'h0, 4'h0, 1'b0, 1'b0);
        add_step(OP_READ,  PORT_DATA, 32'h0000_8044, 32'h0, 4'h0, 1'b0, 1'b0);
        // Dirty line of set 0 goes back to memory
        add_step(OP_READ,  PORT_DATA, 32'h0000_8200, 32'h0, 4'h0, 1'b0, 1'b0);
        add_step(OP_READ,  PORT_DATA, 32'h0000_8008, 32'h0, 4'h0, 1'b0, 1'b0);
        // Both caches miss in the same cycle
        add_step(OP_READ,  PORT_INST, 32'h0000_1100, 32'h0, 4'h0, 1'b0, 1'b1);
        add_step(OP_READ,  PORT_DATA, 32'h0000_8400, 32'h0, 4'h0, 1'b0, 1'b0);
        add_step(OP_READ,  PORT_INST, 32'h0000_1108, 32'h0, 4'h0, 1'b1, 1'b1);
        add_step(OP_WRITE, PORT_DATA, 32'h0000_804c, 32'ha5c30f96, 4'he, 1'b0, 1'b0);
        // Fetch miss against a dirty data miss
        add_step(OP_READ,  PORT_INST, 32'h0000_1204, 32'h0, 4'h0, 1'b0, 1'b1);
        add_step(OP_READ,  PORT_DATA, 32'h0000_8448, 32'h0, 4'h0, 1'b0, 1'b0);
        add_step(OP_READ,  PORT_DATA, 32'h0000_804c, 32'h0, 4'h0, 1'b0, 1'b0);
        add_step(OP_READ,  PORT_DATA, 32'h0000_8044, 32'h0, 4'h0, 1'b0, 1'b0);
        add_step(OP_READ,  PORT_INST, 32'h0000_1200, 32'h0, 4'h0, 1'b1, 1'b0);
    endfunction

    task automatic check_hit_latency(input string port, input int lat);
        assert (lat == 1) else begin
            errors++;
            $display("At %0t a hit on %s answered %0d cycles after the request, not one",
                     $time, port, lat);
        end
    endtask

    task automatic fetch_inst(input step_t s);
        logic [63:0] got;
        int          lat;
        imem_req.addr  = s.addr;
        imem_req.rmask = 1'b1;
        imem_req.wmask = 4'h0;
        imem_req.wdata = 32'h0;
        lat = 0;
        @(negedge clk);
        while (!imem_resp) begin
            @(negedge clk);
            lat++;
        end
        got = '0;
        got[FETCH_BITS-1:0] = imem_rdata;
        @(posedge clk);
        #1;
        imem_req = '0;
        assert (got == s.expected) else begin
            errors++;
            $display("ERR %0t imem_rdata expected %h got %h", $time, s.expected, got);
        end
        if (s.check_lat) begin
            check_hit_latency("imem", lat);
        end
    endtask

    task automatic access_data(input step_t s);
        logic [31:0] got;
        int          lat;
        dmem_req.addr  = s.addr;
        dmem_req.rmask = (s.op == OP_READ);
        dmem_req.wmask = (s.op == OP_WRITE) ? s.mask : 4'h0;
        dmem_req.wdata = s.wdata;
        lat = 0;
        @(negedge clk);
        while (!dmem_resp) begin
            @(negedge clk);
            lat++;
        end
        got = dmem_rdata;
        @(posedge clk);
        #1;
        dmem_req = '0;
        if (s.op == OP_READ) begin
            assert (got == s.expected[31:0]) else begin
                errors++;
                $display("ERR %0t dmem_rdata expected %h got %h",
                         $time, s.expected[31:0], got);
            end
        end
        if (s.check_lat) begin
            check_hit_latency("dmem", lat);
        end
    endtask

    task automatic run_step(input step_t s);
        if (s.port == PORT_INST) begin
            fetch_inst(s);
        end else begin
            access_data(s);
        end
    endtask

    initial begin
        int    idx;
        step_t first;
        step_t second;
        void'($urandom(32'h38bea226));
        rst         = 1'b1;
        imem_req    = '0;
        dmem_req    = '0;
        errors      = 0;
        cur_step    = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        idx = 0;
        while (idx < steps.size()) begin
            cur_step = idx;
            @(posedge clk);
            #1;
            if (steps[idx].paired && idx + 1 < steps.size()) begin
                first  = steps[idx];
                second = steps[idx + 1];
                fork
                    run_step(first);
                    run_step(second);
                join
                idx += 2;
            end else begin
                run_step(steps[idx]);
                idx++;
            end
        end

        repeat (4) @(posedge clk);
        $display("Run finished: %0d steps, %0d errors", steps.size(), errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Budget scales with the number of table rows
    initial begin
        wait (table_ready);
        repeat (steps.size() * CYCLES_STEP) @(posedge clk);
        $display("Timeout: no finish within %0d cycles, step %0d never got its resp",
                 steps.size() * CYCLES_STEP, cur_step);
        $display("Run stopped: %0d errors", errors);
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+design
design/mem_pkg.sv
design/line_cache.sv
design/burst_arbiter.sv
design/mem_subsystem.sv
tb/bmem_model.sv
tb/tb_mem_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
